/* nn_accel.f */
verilog/nn_types_pkg.sv
verilog/nn_ctrl_pkg.sv
verilog/param_mem.sv
verilog/param_arbiter.sv
verilog/host_wb_port.sv
verilog/dense_engine.sv
verilog/nn_accel_top.sv
sim/nn_accel_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module nn_accel_tb -f nn_accel.f -o nn_accel_sim
./obj_dir/nn_accel_sim | tee sim.log

if grep -q "TEST FAIL" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
grep -q "TEST PASS" sim.log || { echo "simulation ended without a result"; exit 1; }

/* sim/nn_accel_tb.sv */
`timescale 1ns/1ps

module nn_accel_tb;

  import nn_types_pkg::*;
  import nn_ctrl_pkg::*;

  localparam int RUN_CYCLES  = 500;   // one layer run with stalls and host traffic
  localparam int LOAD_CYCLES = 3000;  // four layer loads, about 530 cycles each, plus readback
  localparam int MAX_CYCLES  = 6 * RUN_CYCLES + LOAD_CYCLES;

  logic        clk;
  logic        rst_n;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [12:0] wb_adr;
  logic [31:0] wb_dat_w;
  logic [3:0]  wb_sel;
  logic [31:0] wb_dat_r;
  logic        wb_ack;
  logic        act_valid;
  act_t        act;
  logic        act_ready;
  logic        res_valid;
  result_t     res;
  logic        res_ready;
  logic        done;

  integer      seed;
  int          cycles;
  int          total_res;    // results accepted since reset
  int          total_done;
  int          res_base;     // total_res at the start of the current run
  int          last_done_idx;
  string       test_name;
  param_word_t shadow [PARAM_DEPTH];  // host view of the parameter memory
  act_t        acts [N_NEURON];
  result_t     exp_res [N_NEURON];

  nn_accel_top u_nn_accel_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .wb_sel    (wb_sel),
    .wb_dat_r  (wb_dat_r),
    .wb_ack    (wb_ack),
    .act_valid (act_valid),
    .act       (act),
    .act_ready (act_ready),
    .res_valid (res_valid),
    .res       (res),
    .res_ready (res_ready),
    .done      (done)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic stop_with_fail(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_result(input string what, input result_t exp, input result_t got);
    if (exp !== got) begin
      $display("Fail %s %s expected idx %0d value %0d actual idx %0d value %0d",
               test_name, what, exp.idx, exp.value, got.idx, got.value);
      stop_with_fail("result stream mismatch");
    end
  endtask

  task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] got);
    if (exp !== got) begin
      $display("Fail %s %s expected %h actual %h", test_name, what, exp, got);
      stop_with_fail("wishbone read data mismatch");
    end
  endtask

  task automatic check_count(input string what, input int exp, input int got);
    if (exp != got) begin
      $display("Fail %s %s expected %0d actual %0d", test_name, what, exp, got);
      stop_with_fail("done pulse mismatch");
    end
  endtask

  function automatic int rand_below(input int n);
    return int'({$random(seed)} % n);
  endfunction

  function automatic param_word_t rand_word();
    return {$random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  function automatic logic [12:0] param_adr(input int addr, input int lane);
    return {1'b0, addr[7:0], lane[1:0], 2'b00};
  endfunction

  // expected output of neuron k, from the shadow rows of the layer
  function automatic result_t ref_neuron(input int lyr, input int k);
    int      sum;
    wgt_t    w;
    acc_t    v;
    result_t r;
    sum = 0;
    for (int i = 0; i < N_NEURON; i++) begin
      w = shadow[lyr * N_NEURON + i][k*WGT_W +: WGT_W];
      sum += int'(acts[i]) * int'(w);
    end
    w = shadow[BIAS_BASE + lyr][k*WGT_W +: WGT_W];
    v = acc_t'(sum + int'(w));  // low 18 bits only
    if (v < 0) v = '0;          // relu
    r.idx   = k[4:0];
    r.value = v;
    return r;
  endfunction

  // called at a falling edge, returns at the falling edge that saw ack
  task automatic wb_access(input logic we, input logic [12:0] adr, input logic [31:0] data,
                           output logic [31:0] rdata);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = data;
    wb_sel   = 4'hf;
    @(negedge clk);
    while (!wb_ack) @(negedge clk);
    rdata  = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic write_word(input int addr, input param_word_t word);
    logic [31:0] unused;
    for (int lane = 0; lane < 4; lane++) begin
      wb_access(1'b1, param_adr(addr, lane), word[lane*LANE_W +: LANE_W], unused);
    end
    shadow[addr] = word;
  endtask

  task automatic read_back(input int addr, input int lane);
    logic [31:0] rd;
    wb_access(1'b0, param_adr(addr, lane), 32'd0, rd);
    check_word($sformatf("param word %0d lane %0d", addr, lane),
               shadow[addr][lane*LANE_W +: LANE_W], rd);
  endtask

  // n_in rows and n_out neurons used, the rest zero
  task automatic fill_layer(input int lyr, input int n_in, input int n_out, input bit extreme);
    param_word_t word;
    wgt_t        c;
    for (int i = 0; i <= N_NEURON; i++) begin  // i == N_NEURON is the bias row
      for (int k = 0; k < N_NEURON; k++) begin
        c = wgt_t'($random(seed));
        if (k >= n_out || (i < N_NEURON && i >= n_in)) c = '0;
        else if (extreme && k % 4 == 0) c = (i == N_NEURON) ? wgt_t'(7) : wgt_t'(-8);
        else if (extreme && k % 4 == 1) c = (i == N_NEURON) ? wgt_t'(-8) : wgt_t'(7);
        word[k*WGT_W +: WGT_W] = c;
      end
      write_word((i == N_NEURON) ? BIAS_BASE + lyr : lyr * N_NEURON + i, word);
    end
  endtask

  task automatic random_acts();
    for (int i = 0; i < N_NEURON; i++) acts[i] = act_t'($random(seed));
  endtask

  task automatic feed_acts(input int gap_pct);
    for (int i = 0; i < N_NEURON; i++) begin
      while (rand_below(100) < gap_pct) begin
        act_valid = 1'b0;
        @(negedge clk);
      end
      act_valid = 1'b1;
      act       = acts[i];
      while (!act_ready) @(negedge clk);
      @(negedge clk);  // taken on the rising edge in between
    end
    act_valid = 1'b0;
  endtask

  task automatic drive_ready(input int bp_pct);
    while (total_res - res_base < N_NEURON) begin
      res_ready = (rand_below(100) >= bp_pct);
      @(negedge clk);
    end
    res_ready = 1'b0;
  endtask

  task automatic run_layer(input int lyr, input int gap_pct, input int bp_pct, input int n_reads);
    logic [31:0] rd;
    int          done_base;
    int          addr;
    for (int k = 0; k < N_NEURON; k++) exp_res[k] = ref_neuron(lyr, k);
    res_base  = total_res;
    done_base = total_done;
    wb_access(1'b1, {1'b1, REG_CTRL}, {29'd0, lyr[1:0], 1'b1}, rd);
    fork
      feed_acts(gap_pct);
      drive_ready(bp_pct);
      begin
        wb_access(1'b0, {1'b1, REG_STATUS}, 32'd0, rd);
        check_word("status while running", {29'd0, lyr[1:0], 1'b1}, rd);
        repeat (n_reads) begin
          addr = rand_below(4) == 0 ? BIAS_BASE + lyr : lyr * N_NEURON + rand_below(N_NEURON);
          read_back(addr, rand_below(4));
        end
      end
    join
    check_count("done pulses", 1, total_done - done_base);
    check_count("done index", N_NEURON - 1, last_done_idx);
    wb_access(1'b0, {1'b1, REG_STATUS}, 32'd0, rd);
    check_word("status after done", {29'd0, lyr[1:0], 1'b0}, rd);
  endtask

  // compares every accepted result against the reference
  always @(posedge clk) begin
    if (rst_n && res_valid && res_ready) begin
      if (total_res - res_base >= N_NEURON) stop_with_fail("more than 32 results in one run");
      else check_result("result", exp_res[total_res - res_base], res);
      total_res++;
    end
    if (rst_n && done) begin
      total_done++;
      last_done_idx = res.idx;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, the DUT stopped responding", MAX_CYCLES);
      stop_with_fail("simulation did not complete in time");
    end
  end

  initial begin
    seed       = 32'he00855f2;
    cycles     = 0;
    total_res  = 0;
    total_done = 0;
    res_base   = 0;
    rst_n      = 1'b0;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = '0;
    wb_dat_w   = '0;
    wb_sel     = '0;
    act_valid  = 1'b0;
    act        = '0;
    res_ready  = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    test_name = "param_rw";
    write_word(5, rand_word());
    write_word(77, rand_word());
    write_word(BIAS_BASE + 2, rand_word());
    for (int lane = 0; lane < 4; lane++) begin
      read_back(5, lane);
      read_back(77, lane);
      read_back(BIAS_BASE + 2, lane);
    end

    test_name = "layer1_random";
    fill_layer(1, N_NEURON, N_NEURON, 1'b0);
    random_acts();
    run_layer(1, 0, 0, 0);

    // largest reachable sums, half of the checked neurons end negative
    test_name = "relu_wrap";
    fill_layer(2, N_NEURON, N_NEURON, 1'b1);
    for (int i = 0; i < N_NEURON; i++) acts[i] = act_t'(-128);
    run_layer(2, 0, 0, 0);

    test_name = "layer0";
    fill_layer(0, 4, N_NEURON, 1'b0);
    fill_layer(3, N_NEURON, 1, 1'b0);
    random_acts();
    run_layer(0, 0, 0, 0);
    test_name = "layer3";
    random_acts();
    run_layer(3, 0, 0, 0);

    test_name = "backpressure";
    random_acts();
    run_layer(1, 30, 40, 0);

    test_name = "sharing";
    random_acts();
    run_layer(2, 10, 20, 8);

    $display("TEST PASS");
    $finish;
  end

endmodule

/* verilog/dense_engine.sv */
`timescale 1ns/1ps

module dense_engine (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      start,
  input  nn_ctrl_pkg::layer_e       layer,
  output logic                      busy,
  output logic                      eng_req,
  output nn_types_pkg::mem_addr_t   eng_addr,
  input  logic                      eng_gnt,
  input  logic                      eng_rvalid,
  input  nn_types_pkg::param_word_t eng_rdata,
  input  logic                      act_valid,
  input  nn_types_pkg::act_t        act,
  output logic                      act_ready,
  output logic                      res_valid,
  output nn_types_pkg::result_t     res,
  input  logic                      res_ready,
  output logic                      done
);

  import nn_types_pkg::*;
  import nn_ctrl_pkg::*;

  engine_state_t state;
  layer_e        layer_q;
  logic [4:0]    in_idx;     // input index being fetched or accumulated
  logic [4:0]    out_idx;    // next neuron to put on the result stream
  logic          row_ok;     // row register holds the last fetch
  param_word_t   row;
  param_word_t   wrow;       // fresh memory word or the held row
  logic          row_avail;
  logic          act_take;
  logic          res_load;
  logic          res_xfer;
  acc_t          acc [N_NEURON];
  acc_t          bias_sum;
  acc_t          relu_val;

  // sign-extended 4-bit code k of a row
  function automatic acc_t code_at(param_word_t w, int k);
    return acc_t'(wgt_t'(w[k*WGT_W +: WGT_W]));
  endfunction

  assign busy      = (state != S_IDLE);
  assign eng_req   = (state == S_FETCH) || (state == S_BIAS_FETCH);
  assign eng_addr  = (state == S_BIAS_FETCH) ? mem_addr_t'(BIAS_BASE + layer_q)
                                             : {1'b0, layer_q, in_idx};

  assign row_avail = eng_rvalid || row_ok;
  assign wrow      = eng_rvalid ? eng_rdata : row;

  assign act_ready = (state == S_MAC) && row_avail;
  assign act_take  = act_ready && act_valid;

  assign res_xfer  = res_valid && res_ready;
  assign done      = res_xfer && (res.idx == 5'(N_NEURON - 1));
  // one per cycle, stops once the last neuron sits in the output register
  assign res_load  = (state == S_OUT) && row_avail && (!res_valid || res_ready) &&
                     !(res_valid && (res.idx == 5'(N_NEURON - 1)));

  assign bias_sum  = acc[out_idx] + code_at(wrow, int'(out_idx));
  assign relu_val  = bias_sum[ACC_W-1] ? acc_t'(0) : bias_sum;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= S_IDLE;
      layer_q   <= LAYER0;
      in_idx    <= '0;
      out_idx   <= '0;
      row_ok    <= 1'b0;
      res_valid <= 1'b0;
    end else begin
      if (eng_gnt) begin
        row_ok <= 1'b0;   // new word on its way
      end else if (eng_rvalid) begin
        row_ok <= 1'b1;
      end
      case (state)
        S_IDLE: begin
          if (start) begin
            layer_q <= layer;
            in_idx  <= '0;
            state   <= S_FETCH;
          end
        end
        S_FETCH: if (eng_gnt) state <= S_MAC;
        S_MAC: begin
          if (act_take) begin
            in_idx <= in_idx + 5'd1;
            state  <= (in_idx == 5'(N_NEURON - 1)) ? S_BIAS_FETCH : S_FETCH;
          end
        end
        S_BIAS_FETCH: begin
          if (eng_gnt) begin
            out_idx <= '0;
            state   <= S_OUT;
          end
        end
        S_OUT: begin
          if (res_load) begin
            res_valid <= 1'b1;
            out_idx   <= out_idx + 5'd1;
          end else if (res_xfer) begin
            res_valid <= 1'b0;
          end
          if (done) state <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // datapath, all 32 neurons per activation
  always_ff @(posedge clk) begin
    if (eng_rvalid) row <= eng_rdata;
    if ((state == S_IDLE) && start) begin
      for (int k = 0; k < N_NEURON; k++) begin
        acc[k] <= '0;
      end
    end else if (act_take) begin
      for (int k = 0; k < N_NEURON; k++) begin
        acc[k] <= acc[k] + acc_t'(act) * code_at(wrow, k);  // wraps at 18 bits
      end
    end
    if (res_load) begin
      res.idx   <= out_idx;
      res.value <= relu_val;
    end
  end

endmodule

/* verilog/host_wb_port.sv */
`timescale 1ns/1ps

module host_wb_port (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   wb_cyc,
  input  logic                   wb_stb,
  input  logic                   wb_we,
  input  logic [12:0]            wb_adr,
  input  logic [31:0]            wb_dat_w,
  input  logic [3:0]             wb_sel,
  output logic [31:0]            wb_dat_r,
  output logic                   wb_ack,
  output nn_types_pkg::mem_req_t host_req,
  output logic                   host_req_valid,
  input  logic                   host_gnt,
  input  logic                   host_rvalid,
  input  logic [31:0]            host_rdata,
  output logic                   start,
  output nn_ctrl_pkg::layer_e    layer,
  input  logic                   busy
);

  import nn_types_pkg::*;
  import nn_ctrl_pkg::*;

  typedef enum logic [1:0] {
    HP_IDLE,
    HP_REQ,   // waiting for the arbiter
    HP_DATA   // grant seen, memory answers this cycle
  } port_state_t;

  port_state_t state;
  logic        wb_req;
  logic        reg_space;
  logic [31:0] status_word;

  assign wb_req         = wb_cyc && wb_stb && !wb_ack;  // no second hit in the ack cycle
  assign reg_space      = wb_adr[REG_SPACE_BIT];
  assign status_word    = {29'd0, layer, busy};
  assign host_req_valid = (state == HP_REQ);

  // an empty byte select writes nothing, any other select writes the whole lane
  always_comb begin
    host_req.we    = wb_we && (wb_sel != 4'b0000);
    host_req.addr  = wb_adr[11:4];
    host_req.lane  = wb_adr[3:2];
    host_req.wdata = wb_dat_w;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= HP_IDLE;
      wb_ack   <= 1'b0;
      wb_dat_r <= '0;
      start    <= 1'b0;
      layer    <= LAYER0;
    end else begin
      wb_ack <= 1'b0;
      start  <= 1'b0;
      case (state)
        HP_IDLE: begin
          if (wb_req && reg_space) begin
            wb_ack <= 1'b1;
            if (wb_we) begin
              if ((wb_adr[11:0] == REG_CTRL) && !busy) begin
                layer <= layer_e'(wb_dat_w[2:1]);
                start <= wb_dat_w[0];
              end
            end else begin
              wb_dat_r <= (wb_adr[11:0] == REG_STATUS) ? status_word : 32'd0;
            end
          end else if (wb_req) begin
            state <= HP_REQ;  // parameter space goes through the arbiter
          end
        end
        HP_REQ: if (host_gnt) state <= HP_DATA;
        HP_DATA: begin
          if (host_rvalid) begin
            wb_ack   <= 1'b1;
            wb_dat_r <= host_rdata;
            state    <= HP_IDLE;
          end
        end
        default: state <= HP_IDLE;
      endcase
    end
  end

endmodule

/* verilog/nn_accel_top.sv */
`timescale 1ns/1ps

module nn_accel_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wb_cyc,
  input  logic                  wb_stb,
  input  logic                  wb_we,
  input  logic [12:0]           wb_adr,
  input  logic [31:0]           wb_dat_w,
  input  logic [3:0]            wb_sel,
  output logic [31:0]           wb_dat_r,
  output logic                  wb_ack,
  input  logic                  act_valid,
  input  nn_types_pkg::act_t    act,
  output logic                  act_ready,
  output logic                  res_valid,
  output nn_types_pkg::result_t res,
  input  logic                  res_ready,
  output logic                  done
);

  import nn_types_pkg::*;
  import nn_ctrl_pkg::*;

  mem_req_t    host_req;
  logic        host_req_valid;
  logic        host_gnt;
  logic        host_rvalid;
  logic [31:0] host_rdata;
  logic        eng_req;
  mem_addr_t   eng_addr;
  logic        eng_gnt;
  logic        eng_rvalid;
  param_word_t eng_rdata;
  mem_req_t    mem_req;
  logic        mem_en;
  param_word_t mem_rdata;
  logic        start;
  layer_e      layer;
  logic        busy;

  host_wb_port u_host_wb_port (
    .clk            (clk),
    .rst_n          (rst_n),
    .wb_cyc         (wb_cyc),
    .wb_stb         (wb_stb),
    .wb_we          (wb_we),
    .wb_adr         (wb_adr),
    .wb_dat_w       (wb_dat_w),
    .wb_sel         (wb_sel),
    .wb_dat_r       (wb_dat_r),
    .wb_ack         (wb_ack),
    .host_req       (host_req),
    .host_req_valid (host_req_valid),
    .host_gnt       (host_gnt),
    .host_rvalid    (host_rvalid),
    .host_rdata     (host_rdata),
    .start          (start),
    .layer          (layer),
    .busy           (busy)
  );

  param_arbiter u_param_arbiter (
    .clk            (clk),
    .rst_n          (rst_n),
    .host_req       (host_req),
    .host_req_valid (host_req_valid),
    .host_gnt       (host_gnt),
    .host_rvalid    (host_rvalid),
    .host_rdata     (host_rdata),
    .eng_req        (eng_req),
    .eng_addr       (eng_addr),
    .eng_gnt        (eng_gnt),
    .eng_rvalid     (eng_rvalid),
    .eng_rdata      (eng_rdata),
    .mem_req        (mem_req),
    .mem_en         (mem_en),
    .mem_rdata      (mem_rdata)
  );

  param_mem u_param_mem (
    .clk   (clk),
    .req   (mem_req),
    .en    (mem_en),
    .rdata (mem_rdata)
  );

  dense_engine u_dense_engine (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .layer      (layer),
    .busy       (busy),
    .eng_req    (eng_req),
    .eng_addr   (eng_addr),
    .eng_gnt    (eng_gnt),
    .eng_rvalid (eng_rvalid),
    .eng_rdata  (eng_rdata),
    .act_valid  (act_valid),
    .act        (act),
    .act_ready  (act_ready),
    .res_valid  (res_valid),
    .res        (res),
    .res_ready  (res_ready),
    .done       (done)
  );

endmodule

/* verilog/nn_ctrl_pkg.sv */
package nn_ctrl_pkg;

  // matrix engine sequencing
  typedef enum logic [2:0] {
    S_IDLE,
    S_FETCH,       // weight row request for the current input index
    S_MAC,         // wait for row and activation
    S_BIAS_FETCH,
    S_OUT          // bias, relu, result stream
  } engine_state_t;

  typedef enum logic [1:0] {
    LAYER0,
    LAYER1,
    LAYER2,
    LAYER3
  } layer_e;

  // byte offsets inside register space
  typedef enum logic [11:0] {
    REG_CTRL   = 12'h000,  // bit 0 start, bits 2:1 layer
    REG_STATUS = 12'h004   // bit 0 busy, bits 2:1 layer
  } reg_addr_e;

  // byte address bit selecting register space over parameter space
  localparam int REG_SPACE_BIT = 12;

endpackage

/* verilog/nn_types_pkg.sv */
package nn_types_pkg;

  // network geometry
  localparam int N_NEURON    = 32;   // outputs per layer, also activations per layer
  localparam int PARAM_DEPTH = 132;  // 128 weight rows + 4 bias rows
  localparam int BIAS_BASE   = 128;  // bias row of layer n sits at BIAS_BASE + n

  localparam int ACT_W  = 8;
  localparam int WGT_W  = 4;
  localparam int ACC_W  = 18;
  localparam int LANE_W = 32;        // host-visible slice of a memory word
  localparam int WORD_W = N_NEURON * WGT_W;

  typedef logic signed [ACT_W-1:0] act_t;
  typedef logic signed [WGT_W-1:0] wgt_t;
  typedef logic signed [ACC_W-1:0] acc_t;

  // code k in bits 4k+3:4k
  typedef logic [WORD_W-1:0] param_word_t;
  typedef logic [7:0]        mem_addr_t;

  typedef struct packed {
    logic              we;
    mem_addr_t         addr;
    logic [1:0]        lane;   // 32-bit slice of the word
    logic [LANE_W-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic [4:0] idx;    // output neuron
    acc_t       value;
  } result_t;

endpackage

/* verilog/param_arbiter.sv */
`timescale 1ns/1ps

module param_arbiter (
  input  logic                      clk,
  input  logic                      rst_n,
  input  nn_types_pkg::mem_req_t    host_req,
  input  logic                      host_req_valid,
  output logic                      host_gnt,
  output logic                      host_rvalid,
  output logic [31:0]               host_rdata,
  input  logic                      eng_req,
  input  nn_types_pkg::mem_addr_t   eng_addr,
  output logic                      eng_gnt,
  output logic                      eng_rvalid,
  output nn_types_pkg::param_word_t eng_rdata,
  output nn_types_pkg::mem_req_t    mem_req,
  output logic                      mem_en,
  input  nn_types_pkg::param_word_t mem_rdata
);

  import nn_types_pkg::*;

  logic       last_eng;     // engine was served last
  logic [1:0] host_lane_q;  // lane of the host read in flight

  // on conflict the side not served last wins
  assign host_gnt = host_req_valid && (!eng_req || last_eng);
  assign eng_gnt  = eng_req && !host_gnt;
  assign mem_en   = host_gnt || eng_gnt;

  always_comb begin
    if (host_gnt) begin
      mem_req = host_req;
    end else begin
      mem_req      = '0;  // engine only reads
      mem_req.addr = eng_addr;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      last_eng    <= 1'b1;  // first conflict goes to the host
      host_rvalid <= 1'b0;
      eng_rvalid  <= 1'b0;
    end else begin
      host_rvalid <= host_gnt;
      eng_rvalid  <= eng_gnt;
      if (eng_gnt) begin
        last_eng <= 1'b1;
      end else if (host_gnt) begin
        last_eng <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (host_gnt) host_lane_q <= host_req.lane;
  end

  assign host_rdata = mem_rdata[host_lane_q*LANE_W +: LANE_W];
  assign eng_rdata  = mem_rdata;

endmodule

/* verilog/param_mem.sv */
`timescale 1ns/1ps

module param_mem (
  input  logic                      clk,
  input  nn_types_pkg::mem_req_t    req,
  input  logic                      en,
  output nn_types_pkg::param_word_t rdata
);

  import nn_types_pkg::*;

  param_word_t mem [PARAM_DEPTH];

  // single port, one write lane per access
  always_ff @(posedge clk) begin
    if (en) begin
      if (req.we && (req.addr < PARAM_DEPTH)) begin
        mem[req.addr][req.lane*LANE_W +: LANE_W] <= req.wdata;
      end
      // old contents on a write, full row on a read
      rdata <= mem[req.addr];
    end
  end

endmodule
